// ==== filelist.f ====
logic/cpuPkg.sv
logic/cpuSequencer.sv
logic/cpuAlu.sv
logic/cpuRegisters.sv
logic/cpuAddressUnit.sv
logic/cpuCore.sv
verification/clockGen.sv
verification/cpuChecker.sv
verification/cpuCoreAssert.sv
verification/cpuCoreTb.sv

// ==== logic/cpuAddressUnit.sv ====
`timescale 1ns/100ps

module cpuAddressUnit import cpuPkg::*;
(
   input  logic              CLK,
   input  logic              RST_N,
   input  logic              RDY_IN,
   input  logic              pcInc,
   input  logic              branchTake,
   input  addrSrcE           addrSrc,
   input  logic              byteOff,
   input  logic              writeStrobe,
   input  logic [WORD_W-1:0] operand,
   input  logic [WORD_W-1:0] storeData,
   output logic [ADDR_W-1:0] A_OUT,
   output logic [DATA_W-1:0] D_OUT,
   output logic              WE_N
);

   logic [WORD_W-1:0] pc;
   logic [WORD_W-1:0] branchOff;
   logic [WORD_W-1:0] dataAddr;

   // 8-bit relative offset, sign extended
   assign branchOff = {{(WORD_W-DATA_W){operand[DATA_W-1]}}, operand[DATA_W-1:0]};

   always_ff @(posedge CLK)
   begin
      if (!RST_N)
         pc <= RESET_PC;
      else if (RDY_IN)
      begin
         if (pcInc)
            pc <= pc + 16'd1;
         else if (branchTake)
            pc <= pc + branchOff;   // relative to the byte after the offset
      end
   end

   assign dataAddr = operand + {{(WORD_W-1){1'b0}}, byteOff};

   // everything lives in bank 0
   assign A_OUT = (addrSrc == ADDR_PC) ? {{(ADDR_W-WORD_W){1'b0}}, pc} :
                                         {{(ADDR_W-WORD_W){1'b0}}, dataAddr};

   assign D_OUT = byteOff ? storeData[WORD_W-1:DATA_W] : storeData[DATA_W-1:0];
   assign WE_N = ~writeStrobe;

endmodule

// ==== logic/cpuAlu.sv ====
`timescale 1ns/100ps

module cpuAlu import cpuPkg::*;
(
   input  logic [WORD_W-1:0] a,
   input  logic [WORD_W-1:0] b,
   input  aluOpE             aluOp,
   input  logic              wide,
   input  logic              carryIn,
   output logic [WORD_W-1:0] result,
   output logic              n,
   output logic              v,
   output logic              z,
   output logic              c
);

   logic [WORD_W-1:0] bOp;
   logic [WORD_W:0]   sum;
   logic [DATA_W:0]   sumLo;
   logic [WORD_W-1:0] raw;
   logic              arith;
   logic              signA;
   logic              signB;
   logic              signR;

   assign arith = (aluOp == ALU_ADC) || (aluOp == ALU_SBC);
   assign bOp = (aluOp == ALU_SBC) ? ~b : b;   // subtract as a + ~b + carry

   assign sum = {1'b0, a} + {1'b0, bOp} + {{WORD_W{1'b0}}, carryIn};
   assign sumLo = {1'b0, a[DATA_W-1:0]} + {1'b0, bOp[DATA_W-1:0]} + {{DATA_W{1'b0}}, carryIn};

   always_comb
   begin
      case (aluOp)
         ALU_ADC, ALU_SBC:
            raw = sum[WORD_W-1:0];
         ALU_AND:
            raw = a & b;
         ALU_OR:
            raw = a | b;
         ALU_XOR:
            raw = a ^ b;
         ALU_INC:
            raw = a + 16'd1;
         ALU_DEC:
            raw = a - 16'd1;
         default:
            raw = a;   // pass
      endcase
   end

   // 8-bit mode keeps the high byte of a
   assign result = wide ? raw : {a[WORD_W-1:DATA_W], raw[DATA_W-1:0]};

   assign signA = wide ? a[WORD_W-1] : a[DATA_W-1];
   assign signB = wide ? bOp[WORD_W-1] : bOp[DATA_W-1];
   assign signR = wide ? raw[WORD_W-1] : raw[DATA_W-1];

   assign n = signR;
   assign z = wide ? (raw == '0) : (raw[DATA_W-1:0] == '0);
   assign v = arith & (signA == signB) & (signR != signA);   // signed overflow
   assign c = !arith ? carryIn : wide ? sum[WORD_W] : sumLo[DATA_W];

endmodule

// ==== logic/cpuCore.sv ====
`timescale 1ns/100ps

module cpuCore import cpuPkg::*;
(
   input  logic              CLK,
   input  logic              RST_N,
   input  logic              RDY_IN,
   input  logic [DATA_W-1:0] D_IN,
   output logic [DATA_W-1:0] D_OUT,
   output logic [ADDR_W-1:0] A_OUT,
   output logic              WE_N,
   output logic              VPA,
   output logic              VDA,
   output logic              LAST_CYCLE
);

   aluOpE             aluOp;
   regSelE            srcSel;
   regSelE            dstSel;
   addrSrcE           addrSrc;
   logic              wide;
   logic              loadLo;
   logic              loadHi;
   logic [1:0]        flagMode;
   logic              pcInc;
   logic              branchTake;
   logic              writeStrobe;
   logic              byteOff;
   logic [DATA_W-1:0] p;
   logic [WORD_W-1:0] aluA;
   logic [WORD_W-1:0] aluB;
   logic [WORD_W-1:0] aluResult;
   logic [WORD_W-1:0] storeData;
   logic              n;
   logic              v;
   logic              z;
   logic              c;

   cpuSequencer i_sequencer (
      .CLK(CLK), .RST_N(RST_N), .RDY_IN(RDY_IN), .D_IN(D_IN), .p(p),
      .aluOp(aluOp), .srcSel(srcSel), .dstSel(dstSel), .wide(wide),
      .loadLo(loadLo), .loadHi(loadHi), .flagMode(flagMode),
      .pcInc(pcInc), .branchTake(branchTake), .writeStrobe(writeStrobe),
      .addrSrc(addrSrc), .byteOff(byteOff),
      .VPA(VPA), .VDA(VDA), .LAST_CYCLE(LAST_CYCLE)
   );

   cpuAlu i_alu (
      .a(aluA), .b(aluB), .aluOp(aluOp), .wide(wide), .carryIn(p[FLAG_C]),
      .result(aluResult), .n(n), .v(v), .z(z), .c(c)
   );

   cpuRegisters i_registers (
      .CLK(CLK), .RST_N(RST_N), .RDY_IN(RDY_IN), .D_IN(D_IN),
      .srcSel(srcSel), .dstSel(dstSel), .wide(wide),
      .loadLo(loadLo), .loadHi(loadHi), .flagMode(flagMode), .aluOp(aluOp),
      .aluResult(aluResult), .n(n), .v(v), .z(z), .c(c),
      .aluA(aluA), .aluB(aluB), .p(p), .storeData(storeData)
   );

   // aluB is the operand latch, stable outside load cycles
   cpuAddressUnit i_addressUnit (
      .CLK(CLK), .RST_N(RST_N), .RDY_IN(RDY_IN),
      .pcInc(pcInc), .branchTake(branchTake), .addrSrc(addrSrc),
      .byteOff(byteOff), .writeStrobe(writeStrobe),
      .operand(aluB), .storeData(storeData),
      .A_OUT(A_OUT), .D_OUT(D_OUT), .WE_N(WE_N)
   );

endmodule

// ==== logic/cpuPkg.sv ====
package cpuPkg;

   // bus and register widths
   localparam int DATA_W = 8;
   localparam int WORD_W = 16;
   localparam int ADDR_W = 24;

   localparam logic [WORD_W-1:0] RESET_PC = 16'h8000;   // bank 0 entry point

   // status register bit positions, NVMXDIZC
   localparam int FLAG_C = 0;
   localparam int FLAG_Z = 1;
   localparam int FLAG_I = 2;
   localparam int FLAG_D = 3;   // stored only, no decimal arithmetic
   localparam int FLAG_X = 4;
   localparam int FLAG_M = 5;
   localparam int FLAG_V = 6;
   localparam int FLAG_N = 7;

   // 8-bit A and index registers, interrupts masked
   localparam logic [DATA_W-1:0] P_RESET = DATA_W'(
      (0 << FLAG_N) | (0 << FLAG_V) | (1 << FLAG_M) | (1 << FLAG_X) |
      (0 << FLAG_D) | (1 << FLAG_I) | (0 << FLAG_Z) | (0 << FLAG_C));

   // status update modes for the register file
   localparam logic [1:0] FM_NONE = 2'd0;
   localparam logic [1:0] FM_NZ   = 2'd1;
   localparam logic [1:0] FM_NZVC = 2'd2;
   localparam logic [1:0] FM_P    = 2'd3;   // set or clear bits by mask

   // kept 65C816 opcodes, anything else runs as NOP
   typedef enum logic [7:0] {
      OP_LDA_IMM = 8'hA9,
      OP_LDX_IMM = 8'hA2,
      OP_LDY_IMM = 8'hA0,
      OP_ADC_IMM = 8'h69,
      OP_SBC_IMM = 8'hE9,
      OP_AND_IMM = 8'h29,
      OP_ORA_IMM = 8'h09,
      OP_EOR_IMM = 8'h49,
      OP_INX     = 8'hE8,
      OP_DEX     = 8'hCA,
      OP_INY     = 8'hC8,
      OP_DEY     = 8'h88,
      OP_TAX     = 8'hAA,
      OP_TXA     = 8'h8A,
      OP_TAY     = 8'hA8,
      OP_TYA     = 8'h98,
      OP_XBA     = 8'hEB,
      OP_CLC     = 8'h18,
      OP_SEC     = 8'h38,
      OP_REP     = 8'hC2,
      OP_SEP     = 8'hE2,
      OP_STA_ABS = 8'h8D,
      OP_STX_ABS = 8'h8E,
      OP_STY_ABS = 8'h8C,
      OP_BEQ     = 8'hF0,
      OP_BNE     = 8'hD0,
      OP_BCC     = 8'h90,
      OP_BCS     = 8'hB0,
      OP_BRA     = 8'h80,
      OP_NOP     = 8'hEA,
      OP_STP     = 8'hDB
   } opcodeE;

   typedef enum logic [2:0] {
      ALU_PASS,
      ALU_ADC,
      ALU_SBC,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_INC,
      ALU_DEC
   } aluOpE;

   typedef enum logic {
      ADDR_PC,    // program counter
      ADDR_OPR    // operand address plus byte offset
   } addrSrcE;

   typedef enum logic [2:0] {
      SEL_NONE,
      SEL_A,
      SEL_X,
      SEL_Y,
      SEL_OPR
   } regSelE;

   typedef logic [2:0] stepT;

endpackage

// ==== logic/cpuRegisters.sv ====
`timescale 1ns/100ps

module cpuRegisters import cpuPkg::*;
(
   input  logic              CLK,
   input  logic              RST_N,
   input  logic              RDY_IN,
   input  logic [DATA_W-1:0] D_IN,
   input  regSelE            srcSel,
   input  regSelE            dstSel,
   input  logic              wide,
   input  logic              loadLo,
   input  logic              loadHi,
   input  logic [1:0]        flagMode,
   input  aluOpE             aluOp,
   input  logic [WORD_W-1:0] aluResult,
   input  logic              n,
   input  logic              v,
   input  logic              z,
   input  logic              c,
   output logic [WORD_W-1:0] aluA,
   output logic [WORD_W-1:0] aluB,
   output logic [DATA_W-1:0] p,
   output logic [WORD_W-1:0] storeData
);

   logic [WORD_W-1:0] regA;
   logic [WORD_W-1:0] regX;
   logic [WORD_W-1:0] regY;
   logic [DATA_W-1:0] regP;
   logic [DATA_W-1:0] pNext;
   logic [DATA_W-1:0] pMask;
   logic [WORD_W-1:0] opr;
   logic [WORD_W-1:0] oprNext;
   logic [WORD_W-1:0] srcVal;
   logic              swapA;
   logic              xRise;

   // immediate bytes bypass the latch in the cycle they arrive
   assign oprNext = {loadHi ? D_IN : opr[WORD_W-1:DATA_W], loadLo ? D_IN : opr[DATA_W-1:0]};

   always_comb
   begin
      case (srcSel)
         SEL_A:   srcVal = regA;
         SEL_X:   srcVal = regX;
         SEL_Y:   srcVal = regY;
         SEL_OPR: srcVal = oprNext;
         default: srcVal = '0;
      endcase
   end

   // A to A pass only happens for XBA
   assign swapA = (srcSel == SEL_A) && (dstSel == SEL_A) && (aluOp == ALU_PASS);
   assign aluA = swapA ? {regA[DATA_W-1:0], regA[WORD_W-1:DATA_W]} : srcVal;
   assign aluB = oprNext;
   assign storeData = srcVal;
   assign p = regP;

   assign pMask = (srcSel == SEL_OPR) ? oprNext[DATA_W-1:0] : DATA_W'(1 << FLAG_C);

   always_comb
   begin
      pNext = regP;
      case (flagMode)
         FM_NZ:
         begin
            pNext[FLAG_N] = n;
            pNext[FLAG_Z] = z;
         end
         FM_NZVC:
         begin
            pNext[FLAG_N] = n;
            pNext[FLAG_V] = v;
            pNext[FLAG_Z] = z;
            pNext[FLAG_C] = c;
         end
         FM_P:
            pNext = (aluOp == ALU_OR) ? (regP | pMask) : (regP & ~pMask);   // SEP/SEC or REP/CLC
         default:
            ;
      endcase
   end

   assign xRise = ~regP[FLAG_X] & pNext[FLAG_X];

   always_ff @(posedge CLK)
   begin
      if (!RST_N)
      begin
         regA <= '0;
         regX <= '0;
         regY <= '0;
         regP <= P_RESET;
      end
      else if (RDY_IN)
      begin
         case (dstSel)
            SEL_A:
            begin
               regA[DATA_W-1:0] <= aluResult[DATA_W-1:0];
               if (wide || srcSel == SEL_A)   // B survives 8-bit loads and transfers
                  regA[WORD_W-1:DATA_W] <= aluResult[WORD_W-1:DATA_W];
            end
            SEL_X:
               regX <= wide ? aluResult : {8'h00, aluResult[DATA_W-1:0]};
            SEL_Y:
               regY <= wide ? aluResult : {8'h00, aluResult[DATA_W-1:0]};
            default:
               ;
         endcase
         regP <= pNext;
         if (xRise)
         begin
            regX[WORD_W-1:DATA_W] <= 8'h00;   // index regs drop to 8 bits
            regY[WORD_W-1:DATA_W] <= 8'h00;
         end
      end
   end

   always_ff @(posedge CLK)
   begin
      if (RDY_IN)
         opr <= oprNext;
   end

endmodule

// ==== logic/cpuSequencer.sv ====
`timescale 1ns/100ps

module cpuSequencer import cpuPkg::*;
(
   input  logic              CLK,
   input  logic              RST_N,
   input  logic              RDY_IN,
   input  logic [DATA_W-1:0] D_IN,
   input  logic [DATA_W-1:0] p,
   output aluOpE             aluOp,
   output regSelE            srcSel,
   output regSelE            dstSel,
   output logic              wide,
   output logic              loadLo,
   output logic              loadHi,
   output logic [1:0]        flagMode,
   output logic              pcInc,
   output logic              branchTake,
   output logic              writeStrobe,
   output addrSrcE           addrSrc,
   output logic              byteOff,
   output logic              VPA,
   output logic              VDA,
   output logic              LAST_CYCLE
);

   stepT       step;
   opcodeE     ir;
   opcodeE     op;
   logic       stopped;
   regSelE     dstReg;
   logic [1:0] fm;
   logic       isImm;
   logic       isStore;
   logic       isBranch;
   logic       isStop;
   logic       taken;
   logic       last;
   logic       accWide;
   logic       idxWide;

   assign op = (step == 3'd0) ? opcodeE'(D_IN) : ir;   // opcode is on the bus in cycle 0
   assign accWide = ~p[FLAG_M];
   assign idxWide = ~p[FLAG_X];

   // what the instruction does, independent of the cycle
   always_comb
   begin
      aluOp = ALU_PASS;
      srcSel = SEL_NONE;
      dstReg = SEL_NONE;
      fm = FM_NONE;
      wide = 1'b0;
      isImm = 1'b0;
      isStore = 1'b0;
      isBranch = 1'b0;
      isStop = 1'b0;
      taken = 1'b0;
      case (op)
         OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM:
         begin
            isImm = 1'b1;
            srcSel = SEL_OPR;
            fm = FM_NZ;
            dstReg = (op == OP_LDA_IMM) ? SEL_A : (op == OP_LDX_IMM) ? SEL_X : SEL_Y;
            wide = (op == OP_LDA_IMM) ? accWide : idxWide;
         end
         OP_ADC_IMM, OP_SBC_IMM, OP_AND_IMM, OP_ORA_IMM, OP_EOR_IMM:
         begin
            isImm = 1'b1;
            srcSel = SEL_A;
            dstReg = SEL_A;
            wide = accWide;
            fm = (op == OP_ADC_IMM || op == OP_SBC_IMM) ? FM_NZVC : FM_NZ;
            aluOp = (op == OP_ADC_IMM) ? ALU_ADC :
                    (op == OP_SBC_IMM) ? ALU_SBC :
                    (op == OP_AND_IMM) ? ALU_AND :
                    (op == OP_ORA_IMM) ? ALU_OR : ALU_XOR;
         end
         OP_INX, OP_DEX, OP_INY, OP_DEY:
         begin
            srcSel = (op == OP_INX || op == OP_DEX) ? SEL_X : SEL_Y;
            dstReg = srcSel;
            fm = FM_NZ;
            wide = idxWide;
            aluOp = (op == OP_INX || op == OP_INY) ? ALU_INC : ALU_DEC;
         end
         OP_TAX, OP_TAY:
         begin
            srcSel = SEL_A;
            dstReg = (op == OP_TAX) ? SEL_X : SEL_Y;
            fm = FM_NZ;
            wide = idxWide;   // width of the destination
         end
         OP_TXA, OP_TYA:
         begin
            srcSel = (op == OP_TXA) ? SEL_X : SEL_Y;
            dstReg = SEL_A;
            fm = FM_NZ;
            wide = accWide;
         end
         OP_XBA:
         begin
            srcSel = SEL_A;   // register file swaps the bytes
            dstReg = SEL_A;
            fm = FM_NZ;
         end
         OP_CLC, OP_SEC:
         begin
            fm = FM_P;
            aluOp = (op == OP_SEC) ? ALU_OR : ALU_AND;
         end
         OP_REP, OP_SEP:
         begin
            isImm = 1'b1;
            srcSel = SEL_OPR;   // mask comes from the immediate
            fm = FM_P;
            aluOp = (op == OP_SEP) ? ALU_OR : ALU_AND;
         end
         OP_STA_ABS, OP_STX_ABS, OP_STY_ABS:
         begin
            isStore = 1'b1;
            srcSel = (op == OP_STA_ABS) ? SEL_A : (op == OP_STX_ABS) ? SEL_X : SEL_Y;
            wide = (op == OP_STA_ABS) ? accWide : idxWide;
         end
         OP_BEQ, OP_BNE, OP_BCC, OP_BCS, OP_BRA:
         begin
            isBranch = 1'b1;
            taken = (op == OP_BEQ) ? p[FLAG_Z] :
                    (op == OP_BNE) ? ~p[FLAG_Z] :
                    (op == OP_BCC) ? ~p[FLAG_C] :
                    (op == OP_BCS) ? p[FLAG_C] : 1'b1;
         end
         OP_STP:
            isStop = 1'b1;
         default:
            ;
      endcase
   end

   // per-cycle bus and strobe control
   always_comb
   begin
      pcInc = 1'b0;
      branchTake = 1'b0;
      writeStrobe = 1'b0;
      addrSrc = ADDR_PC;
      byteOff = 1'b0;
      loadLo = 1'b0;
      loadHi = 1'b0;
      VPA = 1'b0;
      VDA = 1'b0;
      last = 1'b0;
      if (!stopped)
      begin
         case (step)
            3'd0:
            begin
               pcInc = 1'b1;
               VPA = 1'b1;
               last = isStop;
            end
            3'd1:
               if (isImm || isStore || isBranch)
               begin
                  pcInc = 1'b1;
                  VPA = 1'b1;
                  loadLo = 1'b1;
                  last = (isImm & ~wide) | (isBranch & ~taken);
               end
               else
                  last = 1'b1;   // implied ops finish here
            3'd2:
               if (isBranch)
               begin
                  branchTake = 1'b1;
                  last = 1'b1;
               end
               else
               begin
                  pcInc = 1'b1;
                  VPA = 1'b1;
                  loadHi = 1'b1;
                  last = isImm;
               end
            3'd3:
            begin
               addrSrc = ADDR_OPR;   // low byte write
               VDA = 1'b1;
               writeStrobe = 1'b1;
               last = ~wide;
            end
            3'd4:
            begin
               addrSrc = ADDR_OPR;
               byteOff = 1'b1;
               VDA = 1'b1;
               writeStrobe = 1'b1;
               last = 1'b1;
            end
            default:
               last = 1'b1;
         endcase
      end
   end

   // results only commit in the final cycle
   assign dstSel = last ? dstReg : SEL_NONE;
   assign flagMode = last ? fm : FM_NONE;
   assign LAST_CYCLE = last;

   always_ff @(posedge CLK)
   begin
      if (!RST_N)
      begin
         step <= 3'd0;
         ir <= OP_NOP;
         stopped <= 1'b0;
      end
      else if (RDY_IN && !stopped)
      begin
         if (step == 3'd0)
            ir <= op;
         if (last && isStop)
            stopped <= 1'b1;   // frozen until reset
         step <= last ? 3'd0 : step + 3'd1;
      end
   end

endmodule

// ==== verification/clockGen.sv ====
`timescale 1ns/100ps

module clockGen
(
   output logic CLK,
   output logic RST_N
);

   localparam int PERIOD = 4;   // ns

   initial
   begin
      CLK = 1'b0;
      forever #(PERIOD / 2) CLK = ~CLK;
   end

   // reset held over two rising edges, released mid-cycle
   initial
   begin
      RST_N = 1'b0;
      repeat (2) @(posedge CLK);
      @(negedge CLK);
      RST_N = 1'b1;
   end

endmodule

// ==== verification/cpuChecker.sv ====
`timescale 1ns/100ps

module cpuChecker import cpuPkg::*;
(
   input  logic              CLK,
   input  logic              RST_N,
   input  logic              RDY_IN,
   input  logic              WE_N,
   input  logic              VPA,
   input  logic              VDA,
   input  logic              LAST_CYCLE,
   input  logic [ADDR_W-1:0] A_OUT,
   input  logic [DATA_W-1:0] D_OUT,
   output int                errorCount,
   output int                writeCount
);

   int                expTest[$];
   logic [WORD_W-1:0] expAddr[$];
   logic [DATA_W-1:0] expData[$];
   int                testErrors[0:15] = '{default: 0};
   int                testWrites[0:15] = '{default: 0};
   int                errors = 0;
   int                writes = 0;
   int                idx;
   int                test;
   logic              resetChecked = 1'b0;
   logic              fetchDue = 1'b0;   // previous cycle ended an instruction

   assign errorCount = errors;
   assign writeCount = writes;

   task automatic addExpected(input int testNum, input logic [WORD_W-1:0] addr,
                              input logic [DATA_W-1:0] data);
      expTest.push_back(testNum);
      expAddr.push_back(addr);
      expData.push_back(data);
   endtask

   task automatic reportMissing();
      for (int i = writes; i < expTest.size(); i++)
         $display("test %0d: expected write of %h to %h never happened",
                  expTest[i], expData[i], expAddr[i]);
   endtask

   always @(posedge CLK)
   begin
      // first cycle out of reset fetches from the entry point
      if (RST_N && !resetChecked)
      begin
         resetChecked = 1'b1;
         if (A_OUT !== 24'h008000 || VPA !== 1'b1 || VDA !== 1'b0 || WE_N !== 1'b1)
         begin
            errors++;
            $display("FAIL t=%0t: after reset A_OUT=%h VPA=%b VDA=%b WE_N=%b, %s",
                     $time, A_OUT, VPA, VDA, WE_N,
                     "expected A_OUT=008000 VPA=1 VDA=0 WE_N=1");
         end
      end

      // after a finished instruction comes an opcode fetch or the STP halt
      if (RST_N && fetchDue)
      begin
         fetchDue = 1'b0;
         if (!(VPA === 1'b1 && VDA === 1'b0 && WE_N === 1'b1) &&
             !(VPA === 1'b0 && VDA === 1'b0 && LAST_CYCLE === 1'b0))
         begin
            errors++;
            $display("FAIL t=%0t: cycle after LAST_CYCLE has VPA=%b VDA=%b WE_N=%b %s",
                     $time, VPA, VDA, WE_N, "and is neither a fetch nor the halt");
         end
      end
      if (RST_N && RDY_IN && LAST_CYCLE === 1'b1)
         fetchDue = 1'b1;

      // a write counts once in the cycle where RDY_IN lets it complete
      if (RST_N && RDY_IN && !WE_N)
      begin
         if (writes >= expTest.size())
         begin
            errors++;
            $display("FAIL t=%0t: write of %h to %h after the last expected write",
                     $time, D_OUT, A_OUT);
         end
         else
         begin
            idx = writes;
            test = expTest[idx];
            if (A_OUT !== {{(ADDR_W-WORD_W){1'b0}}, expAddr[idx]} || D_OUT !== expData[idx])
            begin
               errors++;
               testErrors[test]++;
               $display("FAIL t=%0t: test %0d write %0d was %h to %h, expected %h to %h",
                        $time, test, idx, D_OUT, A_OUT, expData[idx], expAddr[idx]);
            end
            testWrites[test]++;
            if (idx == expTest.size() - 1 || expTest[idx+1] != test)   // last write of the test
               $display("test %0d finished: %0d writes, %0d errors",
                        test, testWrites[test], testErrors[test]);
         end
         writes++;
      end
   end

endmodule

// ==== verification/cpuCoreAssert.sv ====
`timescale 1ns/100ps

module cpuCoreAssert import cpuPkg::*;
(
   input logic              CLK,
   input logic              RST_N,
   input logic              RDY_IN,
   input logic              WE_N,
   input logic              VDA,
   input logic [ADDR_W-1:0] A_OUT
);

   int failCount = 0;

   writeHasVda: assert property (@(posedge CLK) disable iff (!RST_N) !WE_N |-> VDA)
      else
      begin
         failCount++;
         $error("WE_N low without VDA");
      end

   noWriteInReset: assert property (@(posedge CLK) !RST_N |-> WE_N)
      else
      begin
         failCount++;
         $error("WE_N low during reset");
      end

   // a stalled cycle keeps the bus where it was
   holdOnStall: assert property (@(posedge CLK) disable iff (!RST_N)
                                 !RDY_IN |=> $stable(A_OUT) && $stable(WE_N))
      else
      begin
         failCount++;
         $error("A_OUT or WE_N moved while RDY_IN was low");
      end

endmodule

bind cpuCore cpuCoreAssert i_assert (
   .CLK(CLK), .RST_N(RST_N), .RDY_IN(RDY_IN), .WE_N(WE_N), .VDA(VDA), .A_OUT(A_OUT)
);

// ==== verification/cpuCoreTb.sv ====
`timescale 1ns/100ps

module cpuCoreTb import cpuPkg::*;
();

   localparam int CLK_PERIOD = 4;
   localparam int QUIET_CYCLES = 20;   // cycles watched after STP
   localparam int TABLE_BASE = 'hF000;
   localparam logic [31:0] LFSR_SEED = 32'h4f97_a8ab;
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

   logic              CLK;
   logic              RST_N;
   logic              RDY_IN = 1'b0;
   logic [DATA_W-1:0] D_IN = '0;
   logic [DATA_W-1:0] D_OUT;
   logic [ADDR_W-1:0] A_OUT;
   logic              WE_N;
   logic              VPA;
   logic              VDA;
   logic              LAST_CYCLE;

   logic [DATA_W-1:0] image [0:65535];   // raw trace where unlisted bytes stay unknown
   logic [DATA_W-1:0] mem [0:65535];
   logic [31:0]       lfsr = LFSR_SEED;
   logic              traceLoaded = 1'b0;
   int                programBytes;
   int                expectCount;
   int                testCount;
   int                timeoutNs;
   int                seenCount;
   int                errorCount;

   clockGen i_clockGen (.CLK(CLK), .RST_N(RST_N));

   cpuCore i_cpuCore (
      .CLK(CLK), .RST_N(RST_N), .RDY_IN(RDY_IN), .D_IN(D_IN), .D_OUT(D_OUT),
      .A_OUT(A_OUT), .WE_N(WE_N), .VPA(VPA), .VDA(VDA), .LAST_CYCLE(LAST_CYCLE)
   );

   cpuChecker i_checker (
      .CLK(CLK), .RST_N(RST_N), .RDY_IN(RDY_IN), .WE_N(WE_N), .VPA(VPA), .VDA(VDA),
      .LAST_CYCLE(LAST_CYCLE), .A_OUT(A_OUT), .D_OUT(D_OUT),
      .errorCount(errorCount), .writeCount(seenCount)
   );

   // galois form stepped once per bit taken
   function automatic logic [31:0] nextLfsr(input logic [31:0] state);
      return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
   endfunction

   function automatic logic [DATA_W-1:0] fillByte(input logic [WORD_W-1:0] addr);
      return addr[15:8] ^ addr[7:0] ^ 8'h5C;
   endfunction

   task automatic loadTrace();
      int idx;
      $readmemh("verification/programTrace.txt", image);
      programBytes = 0;
      expectCount = 0;
      testCount = 0;
      for (int i = 0; i < 65536; i++)
      begin
         if ($isunknown(image[i]))
            mem[i] = fillByte(16'(i));
         else
         begin
            mem[i] = image[i];
            if (i >= 'h8000 && i < TABLE_BASE)
               programBytes++;
         end
      end
      // expected writes take four bytes each and test 00 ends the table
      idx = TABLE_BASE;
      while (idx < 65533 && !$isunknown(image[idx]) && image[idx] != 8'h00)
      begin
         i_checker.addExpected(int'(image[idx]), {image[idx+1], image[idx+2]}, image[idx+3]);
         if (int'(image[idx]) > testCount)
            testCount = int'(image[idx]);
         expectCount++;
         idx += 4;
      end
      timeoutNs = programBytes * 6 * 2 * CLK_PERIOD;   // 6 cycles a byte doubled for stalls
      traceLoaded = 1'b1;
   endtask

   task automatic finishRun();
      int missing;
      int failures;
      missing = (expectCount > seenCount) ? expectCount - seenCount : 0;
      if (missing > 0)
         i_checker.reportMissing();
      failures = errorCount + missing + i_cpuCore.i_assert.failCount;
      $display("%0d tests, %0d of %0d writes seen, %0d compare errors, %0d assertion failures",
               testCount, seenCount, expectCount, errorCount, i_cpuCore.i_assert.failCount);
      if (failures == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   endtask

   // bus reads and random stalls change mid-cycle
   always @(negedge CLK)
   begin
      lfsr = nextLfsr(lfsr);
      RDY_IN <= lfsr[0];
      D_IN <= mem[A_OUT[WORD_W-1:0]];
   end

   always @(posedge CLK)
   begin
      if (RST_N && RDY_IN && !WE_N)
         mem[A_OUT[WORD_W-1:0]] <= D_OUT;
   end

   initial
   begin
      loadTrace();
      wait (RST_N === 1'b1);
      @(posedge CLK);
      while (VPA || VDA || LAST_CYCLE)   // all three low only once STP has run
         @(posedge CLK);
      repeat (QUIET_CYCLES) @(posedge CLK);
      finishRun();
   end

   initial
   begin
      wait (traceLoaded);
      #(timeoutNs);
      $display("timeout after %0d ns: the core never reached STP", timeoutNs);
      i_checker.reportMissing();
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// ==== verification/programTrace.txt ====
// program bytes: @address, then opcode and operand bytes in address order
// expected writes from @F000: test, address high, address low, data; test 00 ends the table
// test 1: 8-bit immediate loads and absolute stores
@8000 A9 5A A2 C3 A0 0F 8D 00 02 8E 01 02 8C 02 02
// test 2: ADC/SBC with the carry set up by CLC/SEC, then AND/ORA/EOR
@800F 18 A9 37 69 48 8D 10 02 38 69 90 8D 11 02
@801D 38 E9 25 8D 12 02 18 E9 0B 8D 13 02
@8029 29 3C 8D 14 02 09 A1 8D 15 02 49 FF 8D 16 02
// test 3: REP #$30, 16-bit immediates and two-byte stores
@8038 C2 30 A9 34 12 8D 20 02 A2 CD AB 8E 22 02
@8046 18 69 FF 0F 8D 24 02
// test 4: DEX/BNE loop, then taken and not-taken BEQ/BCC/BCS and a BRA
@804D A2 05 00 A0 00 00 C8 CA D0 FC
@8057 8C 30 02 8E 32 02 F0 01 E8 8E 34 02
@8063 E8 F0 01 E8 8E 36 02
@806A 38 90 01 E8 B0 01 E8 18 90 01 E8 B0 01 E8 8E 38 02
@807B 80 01 E8 8E 3A 02
// test 5: TAX, XBA, TYA, then SEP #$10 drops the index high bytes
@8081 A9 C8 5E AA EB 8D 40 02 8E 42 02
@808C A0 77 66 98 8D 44 02 E2 10 C2 10 8E 46 02 8C 48 02
// test 6: back to 8 bits, one store, STP, then a store that must never run
@809D E2 30 A9 99 8D 50 02 DB 8D 51 02
// expected writes in bus order
@F000
01 02 00 5A  01 02 01 C3  01 02 02 0F
02 02 10 7F  02 02 11 10  02 02 12 EB  02 02 13 DF
02 02 14 1C  02 02 15 BD  02 02 16 42
03 02 20 34  03 02 21 12  03 02 22 CD  03 02 23 AB
03 02 24 33  03 02 25 22
04 02 30 05  04 02 31 00  04 02 32 00  04 02 33 00
04 02 34 00  04 02 35 00  04 02 36 02  04 02 37 00
04 02 38 04  04 02 39 00  04 02 3A 04  04 02 3B 00
05 02 40 5E  05 02 41 C8  05 02 42 C8  05 02 43 5E
05 02 44 77  05 02 45 66  05 02 46 C8  05 02 47 00
05 02 48 77  05 02 49 00
06 02 50 99
00
